/* all.f */
+incdir+design
design/rv_pkg.sv
design/rv_regfile.sv
design/rv_imm_gen.sv
design/rv_decoder.sv
design/rv_branch_unit.sv
design/rv_credit_counter.sv
design/rv_id_stage.sv
dv/tb_rv_id_stage.sv

/* design/rv_branch_unit.sv */
`include "rv_defs.svh"

module rv_branch_unit (
    input  rv_pkg::ctrl_t       ctrl_i,
    input  logic [`RV_XLEN-1:0] pc_i,
    input  logic [`RV_XLEN-1:0] op1_i,
    input  logic [`RV_XLEN-1:0] op2_i,
    input  logic [`RV_XLEN-1:0] imm_i,
    output logic                branch_taken_o,
    output logic [`RV_XLEN-1:0] branch_addr_o,
    output logic [`RV_XLEN-1:0] link_addr_o
);

    logic eq;
    logic lt;
    logic ltu;
    logic cond;
    logic jump;

    assign eq   = (op1_i == op2_i);
    assign lt   = ($signed(op1_i) < $signed(op2_i));
    assign ltu  = (op1_i < op2_i);
    assign jump = ctrl_i.jal | ctrl_i.jalr;

    always_comb
    begin
        case (ctrl_i.alu_op)
            rv_pkg::ALU_BEQ:  cond = eq;
            rv_pkg::ALU_BNE:  cond = !eq;
            rv_pkg::ALU_BLT:  cond = lt;
            rv_pkg::ALU_BGE:  cond = !lt;
            rv_pkg::ALU_BLTU: cond = ltu;
            rv_pkg::ALU_BGEU: cond = !ltu;
            default:          cond = 1'b0;
        endcase
    end

    assign branch_taken_o = jump | (ctrl_i.branch & cond);

    // jalr is register relative, everything else pc relative
    assign branch_addr_o = ctrl_i.jalr     ? op1_i + imm_i :
                           branch_taken_o  ? pc_i + imm_i  : '0;

    assign link_addr_o = jump ? pc_i + `RV_XLEN'(4) : '0;

endmodule

/* design/rv_credit_counter.sv */
`include "rv_defs.svh"

module rv_credit_counter #(
    parameter int DEPTH = `RV_ID_CREDITS
) (
    input  logic clk,
    input  logic rst,
    input  logic take_i,
    input  logic return_i,
    output logic avail_o
);

    localparam int CW = $clog2(DEPTH + 1);

    logic [CW-1:0] count;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            count <= CW'(DEPTH);
        end
        else if (take_i && !return_i)
        begin
            count <= count - CW'(1);
        end
        // a return at full count is an execute-side error and is dropped
        else if (return_i && !take_i && count != CW'(DEPTH))
        begin
            count <= count + CW'(1);
        end
    end

    assign avail_o = (count != '0);

endmodule

/* design/rv_decoder.sv */
module rv_decoder (
    input  logic [31:0]   inst_i,
    output rv_pkg::ctrl_t ctrl_o
);

    localparam rv_pkg::ctrl_t CTRL_NOP = '{
        alu_op:  rv_pkg::ALU_NOP,
        alu_sel: rv_pkg::SEL_NOP,
        imm_fmt: rv_pkg::IMM_NONE,
        default: 1'b0
    };

    logic [6:0]    opcode;
    logic [2:0]    funct3;
    logic [6:0]    funct7;
    logic          alt;
    logic          valid;
    rv_pkg::ctrl_t ctrl;

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];
    // sub / sra encoding
    assign alt    = (funct7 == 7'b0100000);

    always_comb
    begin
        ctrl  = CTRL_NOP;
        valid = 1'b1;

        case (opcode)
            rv_pkg::OPC_LUI:
            begin
                ctrl.alu_op  = rv_pkg::ALU_OR;
                ctrl.alu_sel = rv_pkg::SEL_LOGIC;
                ctrl.imm_fmt = rv_pkg::IMM_U;
                ctrl.wr_en   = 1'b1;
            end
            rv_pkg::OPC_AUIPC:
            begin
                ctrl.alu_op  = rv_pkg::ALU_AUIPC;
                ctrl.alu_sel = rv_pkg::SEL_ARITH;
                ctrl.imm_fmt = rv_pkg::IMM_U;
                ctrl.wr_en   = 1'b1;
            end
            rv_pkg::OPC_OP_IMM:
            begin
                ctrl.rs1_en  = 1'b1;
                ctrl.wr_en   = 1'b1;
                ctrl.imm_fmt = rv_pkg::IMM_I_SEXT;
                ctrl.alu_sel = rv_pkg::SEL_ARITH;
                case (funct3)
                    3'b000: ctrl.alu_op = rv_pkg::ALU_ADD;
                    3'b010: ctrl.alu_op = rv_pkg::ALU_SLT;
                    3'b011: ctrl.alu_op = rv_pkg::ALU_SLTU;
                    3'b100, 3'b110, 3'b111:
                    begin
                        ctrl.alu_sel = rv_pkg::SEL_LOGIC;
                        ctrl.imm_fmt = rv_pkg::IMM_I_ZEXT;
                        ctrl.alu_op  = (funct3 == 3'b100) ? rv_pkg::ALU_XOR :
                                       (funct3 == 3'b110) ? rv_pkg::ALU_OR  : rv_pkg::ALU_AND;
                    end
                    default:
                    begin
                        // slli, srli, srai
                        ctrl.alu_sel = rv_pkg::SEL_SHIFT;
                        ctrl.imm_fmt = rv_pkg::IMM_SHAMT;
                        ctrl.alu_op  = (funct3 == 3'b001) ? rv_pkg::ALU_SLL :
                                       alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
                        valid = (funct7 == 7'b0) || (alt && funct3 == 3'b101);
                    end
                endcase
            end
            rv_pkg::OPC_OP:
            begin
                ctrl.rs1_en = 1'b1;
                ctrl.rs2_en = 1'b1;
                ctrl.wr_en  = 1'b1;
                case (funct3)
                    3'b000:
                    begin
                        ctrl.alu_op  = alt ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
                        ctrl.alu_sel = rv_pkg::SEL_ARITH;
                    end
                    3'b001:
                    begin
                        ctrl.alu_op  = rv_pkg::ALU_SLL;
                        ctrl.alu_sel = rv_pkg::SEL_SHIFT;
                    end
                    3'b010, 3'b011:
                    begin
                        ctrl.alu_op  = funct3[0] ? rv_pkg::ALU_SLTU : rv_pkg::ALU_SLT;
                        ctrl.alu_sel = rv_pkg::SEL_ARITH;
                    end
                    3'b101:
                    begin
                        ctrl.alu_op  = alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
                        ctrl.alu_sel = rv_pkg::SEL_SHIFT;
                    end
                    default:
                    begin
                        ctrl.alu_sel = rv_pkg::SEL_LOGIC;
                        ctrl.alu_op  = (funct3 == 3'b100) ? rv_pkg::ALU_XOR :
                                       (funct3 == 3'b110) ? rv_pkg::ALU_OR  : rv_pkg::ALU_AND;
                    end
                endcase
                valid = (funct7 == 7'b0) || (alt && (funct3 == 3'b000 || funct3 == 3'b101));
            end
            rv_pkg::OPC_JAL:
            begin
                ctrl.alu_op  = rv_pkg::ALU_JAL;
                ctrl.alu_sel = rv_pkg::SEL_JUMP_BRANCH;
                ctrl.imm_fmt = rv_pkg::IMM_J;
                ctrl.wr_en   = 1'b1;
                ctrl.jal     = 1'b1;
            end
            rv_pkg::OPC_JALR:
            begin
                ctrl.alu_op  = rv_pkg::ALU_JALR;
                ctrl.alu_sel = rv_pkg::SEL_JUMP_BRANCH;
                ctrl.imm_fmt = rv_pkg::IMM_I_SEXT;
                ctrl.rs1_en  = 1'b1;
                ctrl.wr_en   = 1'b1;
                ctrl.jalr    = 1'b1;
                valid        = (funct3 == 3'b000);
            end
            rv_pkg::OPC_BRANCH:
            begin
                ctrl.imm_fmt = rv_pkg::IMM_B;
                ctrl.rs1_en  = 1'b1;
                ctrl.rs2_en  = 1'b1;
                ctrl.branch  = 1'b1;
                case (funct3)
                    3'b000: ctrl.alu_op = rv_pkg::ALU_BEQ;
                    3'b001: ctrl.alu_op = rv_pkg::ALU_BNE;
                    3'b100: ctrl.alu_op = rv_pkg::ALU_BLT;
                    3'b101: ctrl.alu_op = rv_pkg::ALU_BGE;
                    3'b110: ctrl.alu_op = rv_pkg::ALU_BLTU;
                    3'b111: ctrl.alu_op = rv_pkg::ALU_BGEU;
                    default: valid = 1'b0;
                endcase
            end
            default:
            begin
                valid = 1'b0;
            end
        endcase
    end

    // unknown encodings issue as a plain nop
    assign ctrl_o = valid ? ctrl : CTRL_NOP;

endmodule

/* design/rv_defs.svh */
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// data and address width
`define RV_XLEN 32

// architectural registers
`define RV_NREGS 32

// register index width
`define RV_REG_AW 5

// execute-stage buffer slots granted after reset
`define RV_ID_CREDITS 4

`endif

/* design/rv_id_stage.sv */
`include "rv_defs.svh"

module rv_id_stage (
    input  logic               clk,
    input  logic               rst,
    input  logic               fetch_valid_i,
    input  rv_pkg::fetch_pkt_t fetch_i,
    output logic               fetch_ready_o,
    input  rv_pkg::wb_pkt_t    wb_i,
    output logic               id_valid_o,
    output rv_pkg::id_pkt_t    id_o,
    input  logic               credit_return_i
);

    logic                accept;
    rv_pkg::ctrl_t       ctrl;
    logic [`RV_XLEN-1:0] imm;
    logic [`RV_XLEN-1:0] rs1_data;
    logic [`RV_XLEN-1:0] rs2_data;
    logic [`RV_XLEN-1:0] op1;
    logic [`RV_XLEN-1:0] op2;
    logic                branch_taken;
    logic [`RV_XLEN-1:0] branch_addr;
    logic [`RV_XLEN-1:0] link_addr;
    rv_pkg::id_pkt_t     pkt;

    assign accept = fetch_valid_i & fetch_ready_o;

    rv_regfile u_regfile (
        .clk        (clk),
        .rst        (rst),
        .wb_i       (wb_i),
        .rs1_addr_i (fetch_i.inst[19:15]),
        .rs2_addr_i (fetch_i.inst[24:20]),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    rv_decoder u_decoder (
        .inst_i (fetch_i.inst),
        .ctrl_o (ctrl)
    );

    rv_imm_gen u_imm_gen (
        .inst_i    (fetch_i.inst),
        .imm_fmt_i (ctrl.imm_fmt),
        .imm_o     (imm)
    );

    // disabled read ports carry the immediate
    assign op1 = ctrl.rs1_en ? rs1_data : imm;
    assign op2 = ctrl.rs2_en ? rs2_data : imm;

    rv_branch_unit u_branch_unit (
        .ctrl_i         (ctrl),
        .pc_i           (fetch_i.pc),
        .op1_i          (op1),
        .op2_i          (op2),
        .imm_i          (imm),
        .branch_taken_o (branch_taken),
        .branch_addr_o  (branch_addr),
        .link_addr_o    (link_addr)
    );

    rv_credit_counter #(
        .DEPTH (`RV_ID_CREDITS)
    ) u_credit_counter (
        .clk      (clk),
        .rst      (rst),
        .take_i   (accept),
        .return_i (credit_return_i),
        .avail_o  (fetch_ready_o)
    );

    always_comb
    begin
        pkt.pc           = fetch_i.pc;
        pkt.alu_op       = ctrl.alu_op;
        pkt.alu_sel      = ctrl.alu_sel;
        pkt.op1          = op1;
        pkt.op2          = op2;
        pkt.offset       = imm;
        pkt.wr_en        = ctrl.wr_en;
        pkt.wr_addr      = ctrl.wr_en ? fetch_i.inst[11:7] : '0;
        pkt.link_addr    = link_addr;
        pkt.branch_taken = branch_taken;
        pkt.branch_addr  = branch_addr;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            id_valid_o <= 1'b0;
        end
        else
        begin
            id_valid_o <= accept;
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            id_o <= pkt;
        end
    end

endmodule

/* design/rv_imm_gen.sv */
`include "rv_defs.svh"

module rv_imm_gen (
    input  logic [31:0]         inst_i,
    input  rv_pkg::imm_fmt_e    imm_fmt_i,
    output logic [`RV_XLEN-1:0] imm_o
);

    always_comb
    begin
        case (imm_fmt_i)
            rv_pkg::IMM_I_SEXT:
            begin
                imm_o = {{(`RV_XLEN-12){inst_i[31]}}, inst_i[31:20]};
            end
            // logic immediates are zero-extended
            rv_pkg::IMM_I_ZEXT:
            begin
                imm_o = {{(`RV_XLEN-12){1'b0}}, inst_i[31:20]};
            end
            rv_pkg::IMM_SHAMT:
            begin
                imm_o = {{(`RV_XLEN-5){1'b0}}, inst_i[24:20]};
            end
            rv_pkg::IMM_U:
            begin
                imm_o = {inst_i[31:12], 12'h000};
            end
            rv_pkg::IMM_J:
            begin
                imm_o = {{(`RV_XLEN-20){inst_i[31]}}, inst_i[19:12], inst_i[20],
                         inst_i[30:21], 1'b0};
            end
            rv_pkg::IMM_B:
            begin
                imm_o = {{(`RV_XLEN-12){inst_i[31]}}, inst_i[7], inst_i[30:25],
                         inst_i[11:8], 1'b0};
            end
            default:
            begin
                imm_o = '0;
            end
        endcase
    end

endmodule

/* design/rv_pkg.sv */
`include "rv_defs.svh"

package rv_pkg;

    // kept major opcodes
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011
    } opcode_e;

    typedef enum logic [4:0] {
        ALU_NOP,
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_AUIPC,
        ALU_JAL,
        ALU_JALR,
        ALU_BEQ,
        ALU_BNE,
        ALU_BLT,
        ALU_BGE,
        ALU_BLTU,
        ALU_BGEU
    } alu_op_e;

    // result class seen by execute
    typedef enum logic [2:0] {
        SEL_NOP,
        SEL_LOGIC,
        SEL_ARITH,
        SEL_SHIFT,
        SEL_JUMP_BRANCH
    } alu_sel_e;

    typedef enum logic [2:0] {
        IMM_I_SEXT,
        IMM_I_ZEXT,
        IMM_SHAMT,
        IMM_U,
        IMM_J,
        IMM_B,
        IMM_NONE
    } imm_fmt_e;

    typedef struct packed {
        logic [`RV_XLEN-1:0] pc;
        logic [31:0]         inst;
    } fetch_pkt_t;

    typedef struct packed {
        logic                  en;
        logic [`RV_REG_AW-1:0] addr;
        logic [`RV_XLEN-1:0]   data;
    } wb_pkt_t;

    typedef struct packed {
        alu_op_e  alu_op;
        alu_sel_e alu_sel;
        imm_fmt_e imm_fmt;
        logic     rs1_en;
        logic     rs2_en;
        logic     wr_en;
        logic     branch;
        logic     jal;
        logic     jalr;
    } ctrl_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0]   pc;
        alu_op_e               alu_op;
        alu_sel_e              alu_sel;
        logic [`RV_XLEN-1:0]   op1;
        logic [`RV_XLEN-1:0]   op2;
        logic [`RV_XLEN-1:0]   offset;
        logic                  wr_en;
        logic [`RV_REG_AW-1:0] wr_addr;
        logic [`RV_XLEN-1:0]   link_addr;
        logic                  branch_taken;
        logic [`RV_XLEN-1:0]   branch_addr;
    } id_pkt_t;

endpackage

/* design/rv_regfile.sv */
`include "rv_defs.svh"

module rv_regfile (
    input  logic                  clk,
    input  logic                  rst,
    input  rv_pkg::wb_pkt_t       wb_i,
    input  logic [`RV_REG_AW-1:0] rs1_addr_i,
    input  logic [`RV_REG_AW-1:0] rs2_addr_i,
    output logic [`RV_XLEN-1:0]   rs1_data_o,
    output logic [`RV_XLEN-1:0]   rs2_data_o
);

    logic [`RV_XLEN-1:0] regs [`RV_NREGS];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < `RV_NREGS; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wb_i.en && wb_i.addr != '0)
        begin
            regs[wb_i.addr] <= wb_i.data;
        end
    end

    // x0 always reads as zero
    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule

/* dv/tb_rv_id_stage.sv */
`include "rv_defs.svh"

module tb_rv_id_stage;

    localparam int NUM_INSTR = 2000;
    // about two cycles per accept on average so 20 per accept is ample
    localparam int MAX_CYCLES = NUM_INSTR * 20;

    logic               clk;
    logic               rst;
    logic               fetch_valid;
    rv_pkg::fetch_pkt_t fetch;
    logic               fetch_ready;
    rv_pkg::wb_pkt_t    wb;
    logic               id_valid;
    rv_pkg::id_pkt_t    id_pkt;
    logic               credit_return;

    logic [31:0]     rf [`RV_NREGS];
    rv_pkg::id_pkt_t exp_q [$];
    int              slot_q [$];
    integer          seed;
    int              cycles = 0;
    int              credits;
    int              in_flight;
    int              accepted;
    int              issued;
    int              mismatches;
    int              other_errs;
    logic            acc;
    logic            ret;

    rv_id_stage u_dut (
        .clk             (clk),
        .rst             (rst),
        .fetch_valid_i   (fetch_valid),
        .fetch_i         (fetch),
        .fetch_ready_o   (fetch_ready),
        .wb_i            (wb),
        .id_valid_o      (id_valid),
        .id_o            (id_pkt),
        .credit_return_i (credit_return)
    );

    initial
    begin
        clk = 1'b0;
    end

    always #50 clk = ~clk;

    always @(posedge clk) cycles <= cycles + 1;

    // mostly legal encodings, a few raw words
    function automatic logic [31:0] gen_inst();
        logic [31:0] w;
        logic [31:0] r;
        logic [2:0]  f3;
        int          kind;
        w = $random(seed);
        r = $random(seed);
        f3 = w[14:12];
        kind = r % 20;
        if (kind == 0)
        begin
            // raw word with a likely unknown opcode
        end
        else if (kind <= 2)
        begin
            w[6:0] = (kind == 1) ? 7'h37 : 7'h17;
        end
        else if (kind <= 6)
        begin
            w[6:0] = 7'h13;
            if (f3 == 3'd1 || f3 == 3'd5)
            begin
                w[31:25] = (f3 == 3'd5 && r[8]) ? 7'h20 : 7'h00;
            end
        end
        else if (kind <= 10)
        begin
            w[6:0] = 7'h33;
            w[31:25] = (r[8] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00;
        end
        else if (kind <= 12)
        begin
            w[6:0] = (kind == 11) ? 7'h6f : 7'h67;
            if (kind == 12)
            begin
                w[14:12] = 3'd0;
            end
        end
        else
        begin
            w[6:0] = 7'h63;
            w[14:12] = (f3[2:1] == 2'b01) ? {1'b1, f3[1:0]} : f3;
            // equal operands now and then
            if (r[9:8] == 2'b00)
            begin
                w[24:20] = w[19:15];
            end
        end
        return w;
    endfunction

    function automatic rv_pkg::id_pkt_t predict(input logic [31:0] pc, input logic [31:0] inst);
        rv_pkg::id_pkt_t p;
        logic [31:0] rs1_v;
        logic [31:0] rs2_v;
        logic [31:0] i_imm;
        logic [31:0] imm;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic        use1;
        logic        use2;
        logic        ok;
        rs1_v = rf[inst[19:15]];
        rs2_v = rf[inst[24:20]];
        i_imm = {{20{inst[31]}}, inst[31:20]};
        f3 = inst[14:12];
        f7 = inst[31:25];
        p = '0;
        p.pc = pc;
        p.alu_op = rv_pkg::ALU_NOP;
        p.alu_sel = rv_pkg::SEL_NOP;
        use1 = 1'b0;
        use2 = 1'b0;
        ok = 1'b1;
        imm = '0;
        case (inst[6:0])
            7'h37:
            begin
                p.alu_op = rv_pkg::ALU_OR;
                p.alu_sel = rv_pkg::SEL_LOGIC;
                imm = {inst[31:12], 12'h000};
                p.wr_en = 1'b1;
            end
            7'h17:
            begin
                p.alu_op = rv_pkg::ALU_AUIPC;
                p.alu_sel = rv_pkg::SEL_ARITH;
                imm = {inst[31:12], 12'h000};
                p.wr_en = 1'b1;
            end
            7'h13:
            begin
                use1 = 1'b1;
                p.wr_en = 1'b1;
                p.alu_sel = rv_pkg::SEL_ARITH;
                imm = i_imm;
                case (f3)
                    3'd0: p.alu_op = rv_pkg::ALU_ADD;
                    3'd2: p.alu_op = rv_pkg::ALU_SLT;
                    3'd3: p.alu_op = rv_pkg::ALU_SLTU;
                    3'd1, 3'd5:
                    begin
                        p.alu_sel = rv_pkg::SEL_SHIFT;
                        imm = {27'd0, inst[24:20]};
                        p.alu_op = (f3 == 3'd1) ? rv_pkg::ALU_SLL :
                                   ((f7 == 7'h20) ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL);
                        ok = (f7 == 7'h00) || (f7 == 7'h20 && f3 == 3'd5);
                    end
                    default:
                    begin
                        // xori, ori, andi take a zero-extended immediate
                        p.alu_sel = rv_pkg::SEL_LOGIC;
                        imm = {20'd0, inst[31:20]};
                        p.alu_op = (f3 == 3'd4) ? rv_pkg::ALU_XOR :
                                   ((f3 == 3'd6) ? rv_pkg::ALU_OR : rv_pkg::ALU_AND);
                    end
                endcase
            end
            7'h33:
            begin
                use1 = 1'b1;
                use2 = 1'b1;
                p.wr_en = 1'b1;
                ok = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
                p.alu_sel = (f3 == 3'd1 || f3 == 3'd5) ? rv_pkg::SEL_SHIFT :
                            ((f3 == 3'd4 || f3 >= 3'd6) ? rv_pkg::SEL_LOGIC : rv_pkg::SEL_ARITH);
                case (f3)
                    3'd0: p.alu_op = (f7 == 7'h20) ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
                    3'd1: p.alu_op = rv_pkg::ALU_SLL;
                    3'd2: p.alu_op = rv_pkg::ALU_SLT;
                    3'd3: p.alu_op = rv_pkg::ALU_SLTU;
                    3'd4: p.alu_op = rv_pkg::ALU_XOR;
                    3'd5: p.alu_op = (f7 == 7'h20) ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
                    3'd6: p.alu_op = rv_pkg::ALU_OR;
                    default: p.alu_op = rv_pkg::ALU_AND;
                endcase
            end
            7'h6f:
            begin
                p.alu_op = rv_pkg::ALU_JAL;
                p.alu_sel = rv_pkg::SEL_JUMP_BRANCH;
                p.wr_en = 1'b1;
                imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
                p.branch_taken = 1'b1;
                p.branch_addr = pc + imm;
                p.link_addr = pc + 32'd4;
            end
            7'h67:
            begin
                ok = (f3 == 3'd0);
                use1 = 1'b1;
                p.alu_op = rv_pkg::ALU_JALR;
                p.alu_sel = rv_pkg::SEL_JUMP_BRANCH;
                p.wr_en = 1'b1;
                imm = i_imm;
                p.branch_taken = 1'b1;
                p.branch_addr = rs1_v + imm;
                p.link_addr = pc + 32'd4;
            end
            7'h63:
            begin
                // branches leave the result class at nop
                use1 = 1'b1;
                use2 = 1'b1;
                ok = (f3[2:1] != 2'b01);
                imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
                case (f3)
                    3'd0: p.alu_op = rv_pkg::ALU_BEQ;
                    3'd1: p.alu_op = rv_pkg::ALU_BNE;
                    3'd4: p.alu_op = rv_pkg::ALU_BLT;
                    3'd5: p.alu_op = rv_pkg::ALU_BGE;
                    3'd6: p.alu_op = rv_pkg::ALU_BLTU;
                    default: p.alu_op = rv_pkg::ALU_BGEU;
                endcase
                case (f3)
                    3'd0: p.branch_taken = (rs1_v == rs2_v);
                    3'd1: p.branch_taken = (rs1_v != rs2_v);
                    3'd4: p.branch_taken = ($signed(rs1_v) < $signed(rs2_v));
                    3'd5: p.branch_taken = ($signed(rs1_v) >= $signed(rs2_v));
                    3'd6: p.branch_taken = (rs1_v < rs2_v);
                    default: p.branch_taken = (rs1_v >= rs2_v);
                endcase
                p.branch_addr = p.branch_taken ? pc + imm : 32'd0;
            end
            default:
            begin
                ok = 1'b0;
            end
        endcase
        p.op1 = use1 ? rs1_v : imm;
        p.op2 = use2 ? rs2_v : imm;
        p.offset = imm;
        p.wr_addr = p.wr_en ? inst[11:7] : 5'd0;
        if (!ok)
        begin
            p = '0;
            p.pc = pc;
            p.alu_op = rv_pkg::ALU_NOP;
            p.alu_sel = rv_pkg::SEL_NOP;
        end
        return p;
    endfunction

    task automatic check_field(input string field, input int n, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        assert (exp_v === act_v)
        else
        begin
            $display("mismatch issue %0d %s: expected %h, actual %h", n, field, exp_v, act_v);
            mismatches++;
        end
    endtask

    task automatic compare_pkt(input rv_pkg::id_pkt_t e, input rv_pkg::id_pkt_t a, input int n);
        check_field("pc", n, e.pc, a.pc);
        check_field("alu_op", n, 32'(e.alu_op), 32'(a.alu_op));
        check_field("alu_sel", n, 32'(e.alu_sel), 32'(a.alu_sel));
        check_field("op1", n, e.op1, a.op1);
        check_field("op2", n, e.op2, a.op2);
        check_field("offset", n, e.offset, a.offset);
        check_field("wr_en", n, 32'(e.wr_en), 32'(a.wr_en));
        check_field("wr_addr", n, 32'(e.wr_addr), 32'(a.wr_addr));
        check_field("link_addr", n, e.link_addr, a.link_addr);
        check_field("branch_taken", n, 32'(e.branch_taken), 32'(a.branch_taken));
        check_field("branch_addr", n, e.branch_addr, a.branch_addr);
    endtask

    task automatic drive_inputs();
        logic [31:0] r;
        int          k;
        credit_return = 1'b0;
        k = 0;
        // consumer frees one due slot per cycle
        while (k < slot_q.size() && !credit_return)
        begin
            if (slot_q[k] <= cycles)
            begin
                credit_return = 1'b1;
                slot_q.delete(k);
            end
            k++;
        end
        // an instruction that was not taken stays on the bus
        if (!(fetch_valid && !acc))
        begin
            r = $random(seed);
            fetch.pc = {r[31:2], 2'b00};
            fetch.inst = gen_inst();
            r = $random(seed);
            fetch_valid = (accepted < NUM_INSTR) && (r[3:0] < 4'd11);
        end
        r = $random(seed);
        wb.en = r[0];
        wb.addr = (r[2:1] == 2'b00) ? fetch.inst[19:15] : r[7:3];
        wb.data = $random(seed);
    endtask

    task automatic check_cycle();
        rv_pkg::id_pkt_t e;
        assert (id_valid == acc)
        else
        begin
            $display("id_valid_o is %0b one cycle after an accept flag of %0b", id_valid, acc);
            other_errs++;
        end
        if (id_valid)
        begin
            in_flight++;
        end
        assert (in_flight <= `RV_ID_CREDITS)
        else
        begin
            $display("%0d packets are outstanding at execute, more than the %0d credits",
                     in_flight, `RV_ID_CREDITS);
            other_errs++;
        end
        if (exp_q.size() != 0)
        begin
            e = exp_q.pop_front();
            if (id_valid)
            begin
                compare_pkt(e, id_pkt, issued);
            end
            issued++;
        end
        assert (fetch_ready == (credits != 0))
        else
        begin
            $display("fetch_ready_o is %0b while the model holds %0d credits", fetch_ready,
                     credits);
            other_errs++;
        end
        acc = fetch_valid && (credits != 0);
        ret = credit_return;
        if (acc)
        begin
            exp_q.push_back(predict(fetch.pc, fetch.inst));
        end
    endtask

    task automatic update_model();
        if (acc)
        begin
            credits--;
            accepted++;
            slot_q.push_back(cycles + ({$random(seed)} % 7));
        end
        if (ret)
        begin
            credits++;
            in_flight--;
        end
        if (wb.en && wb.addr != 5'd0)
        begin
            rf[wb.addr] = wb.data;
        end
    endtask

    task automatic finish_run();
        $display("errors: %0d mismatches, %0d other failures", mismatches, other_errs);
        if (mismatches == 0 && other_errs == 0)
        begin
            $display("Finished with no errors");
        end
        else
        begin
            $display("Finished with errors");
        end
        $finish;
    endtask

    initial
    begin
        seed = 32'hc651abf5;
        rst = 1'b1;
        fetch_valid = 1'b0;
        fetch = '0;
        wb = '0;
        credit_return = 1'b0;
        credits = `RV_ID_CREDITS;
        in_flight = 0;
        acc = 1'b0;
        ret = 1'b0;
        accepted = 0;
        issued = 0;
        mismatches = 0;
        other_errs = 0;
        for (int i = 0; i < `RV_NREGS; i++)
        begin
            rf[i] = '0;
        end
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        assert (!id_valid && fetch_ready)
        else
        begin
            $display("after reset id_valid_o is not low or fetch_ready_o is not high");
            other_errs++;
        end
        @(posedge clk);
        #1;
        while (accepted < NUM_INSTR || exp_q.size() != 0)
        begin
            drive_inputs();
            @(negedge clk);
            check_cycle();
            @(posedge clk);
            #1;
            update_model();
        end
        finish_run();
    end

    initial
    begin
        while (cycles < MAX_CYCLES)
        begin
            @(posedge clk);
        end
        $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
        other_errs++;
        finish_run();
    end

endmodule

/* run.sh */
#!/bin/sh

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -f all.f --top-module tb_rv_id_stage -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Finished with no errors" sim.log; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1
